// ==== dv/video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_tb import video_pkg::*; ();

	localparam int h_total      = 40;
	localparam int h_act        = 24;
	localparam int h_sync_beg   = 28;
	localparam int h_sync_end   = 32;
	localparam int v_total      = 12;
	localparam int v_act        = 8;
	localparam int v_sync_beg   = 9;
	localparam int v_sync_end   = 10;
	localparam int frame_cycles = h_total * v_total;
	localparam int wait_limit   = 2 * frame_cycles;

	// cpu port register numbers
	localparam int reg_border  = 0;
	localparam int reg_vconf   = 1;
	localparam int reg_palsel  = 2;
	localparam int reg_hint    = 3;
	localparam int reg_vint_lo = 4;
	localparam int reg_vint_hi = 5;

	logic             clk;
	logic             arst_n;
	logic [7:0]       d;
	logic             border_wr;
	logic             vconf_wr;
	logic             palsel_wr;
	logic             hint_beg_wr;
	logic             vint_begl_wr;
	logic             vint_begh_wr;
	pix_idx_t         cram_addr;
	rgb_t             cram_data;
	logic             cram_we;
	logic [lb_aw-1:0] ts_waddr;
	logic [7:0]       ts_wdata;
	logic             ts_we;
	logic [4:0]       vred;
	logic [4:0]       vgrn;
	logic [4:0]       vblu;
	logic             hsync;
	logic             vsync;
	logic             de;
	logic             int_start;
	line_t            line;

	// reference model state
	rgb_t        pal_model [256];
	pix_idx_t    border_model;
	logic [7:0]  wr_bytes [h_act];
	logic [7:0]  exp_bytes [h_act];
	logic [31:0] lcg_state;

	video_top #(
		.h_total    (h_total),
		.h_act      (h_act),
		.h_sync_beg (h_sync_beg),
		.h_sync_end (h_sync_end),
		.v_total    (v_total),
		.v_act      (v_act),
		.v_sync_beg (v_sync_beg),
		.v_sync_end (v_sync_end)
	) i_video_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vconf_wr     (vconf_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.cram_addr    (cram_addr),
		.cram_data    (cram_data),
		.cram_we      (cram_we),
		.ts_waddr     (ts_waddr),
		.ts_wdata     (ts_wdata),
		.ts_we        (ts_we),
		.vred         (vred),
		.vgrn         (vgrn),
		.vblu         (vblu),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.int_start    (int_start),
		.line         (line)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// colour the display should show for one overlay byte
	function automatic rgb_t expect_pixel(input logic [7:0] b, input logic m16,
			input logic [3:0] ps);
		if (m16) begin
			if (b[3:0] == 4'h0)
				return pal_model[border_model];
			return pal_model[{ps, b[3:0]}];
		end else begin
			if (b == 8'h00)
				return pal_model[border_model];
			return pal_model[b];
		end
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_rgb(input rgb_t exp, input rgb_t act, input string what);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0t: %s, expected %h got %h",
				$time, what, exp, act));
	endtask

	task automatic check_line(input line_t exp, input line_t act, input string what);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0t: %s, expected line %0d got %0d",
				$time, what, exp, act));
	endtask

	task automatic check_count(input int exp, input int act, input string what);
		if (act != exp)
			abort_run($sformatf("mismatch at %0t: %s, expected %0d got %0d",
				$time, what, exp, act));
	endtask

	task automatic write_reg(input int which, input logic [7:0] val);
		@(posedge clk);
		d            <= val;
		border_wr    <= (which == reg_border);
		vconf_wr     <= (which == reg_vconf);
		palsel_wr    <= (which == reg_palsel);
		hint_beg_wr  <= (which == reg_hint);
		vint_begl_wr <= (which == reg_vint_lo);
		vint_begh_wr <= (which == reg_vint_hi);
		if (which == reg_border)
			border_model = val;
		@(posedge clk);
		border_wr    <= 1'b0;
		vconf_wr     <= 1'b0;
		palsel_wr    <= 1'b0;
		hint_beg_wr  <= 1'b0;
		vint_begl_wr <= 1'b0;
		vint_begh_wr <= 1'b0;
	endtask

	task automatic fill_palette();
		rgb_t c;
		for (int i = 0; i < 256; i++) begin
			// every entry differs, upper bits land in green
			c.r = 5'(i);
			c.g = {3'(i >> 5), 2'b01};
			c.b = 5'(i >> 3) ^ 5'(i);
			pal_model[i] = c;
			@(posedge clk);
			cram_addr <= 8'(i);
			cram_data <= c;
			cram_we   <= 1'b1;
		end
		@(posedge clk);
		cram_we <= 1'b0;
	endtask

	// returns on the negedge right after line turns to target
	task automatic wait_line_start(input line_t target);
		line_t prev;
		int    n;
		@(negedge clk);
		n = 0;
		do begin
			prev = line;
			@(negedge clk);
			n++;
			if (n > wait_limit)
				abort_run($sformatf("timeout while waiting for line %0d to start", target));
		end while (line != target || prev == target);
	endtask

	task automatic wait_de_rise();
		logic prev;
		int   n;
		@(negedge clk);
		n = 0;
		do begin
			prev = de;
			@(negedge clk);
			n++;
			if (n > wait_limit)
				abort_run("timeout while waiting for de to rise");
		end while (!(de && !prev));
	endtask

	// overlay bytes for the next line, with a palsel write in the middle if asked
	task automatic write_overlay(input logic mid_write, input logic [3:0] mid_palsel);
		logic [7:0] b;
		for (int k = 0; k < h_act; k++) begin
			b = lcg_byte();
			if (k % 6 == 5)
				b = 8'h00;
			else if (k % 6 == 2)
				b = {b[7:4] | 4'h1, 4'h0};
			wr_bytes[k] = b;
			@(posedge clk);
			ts_waddr <= lb_aw'(k);
			ts_wdata <= b;
			ts_we    <= 1'b1;
			if (mid_write && k == h_act / 2) begin
				d         <= {4'h0, mid_palsel};
				palsel_wr <= 1'b1;
			end else begin
				palsel_wr <= 1'b0;
			end
		end
		@(posedge clk);
		ts_we     <= 1'b0;
		palsel_wr <= 1'b0;
	endtask

	task automatic compare_line_pixels(input line_t exp_line, input logic m16,
			input logic [3:0] ps);
		wait_de_rise();
		check_line(exp_line, line, "line at de rise");
		for (int k = 0; k < h_act; k++) begin
			if (k > 0)
				@(negedge clk);
			if (!de)
				abort_run($sformatf("de fell early on line %0d at pixel %0d", exp_line, k));
			check_rgb(expect_pixel(exp_bytes[k], m16, ps), {vred, vgrn, vblu},
				$sformatf("line %0d pixel %0d", exp_line, k));
		end
	endtask

	task automatic border_frame();
		int n_de;
		n_de = 0;
		write_reg(reg_border, 8'h5a);
		wait_line_start(9'd0);
		for (int i = 0; i < frame_cycles; i++) begin
			if (de) begin
				check_rgb(pal_model[border_model], {vred, vgrn, vblu}, "border pixel");
				n_de++;
			end
			@(negedge clk);
		end
		check_count(h_act * v_act, n_de, "de pixels per frame");
	endtask

	task automatic sync_pulses();
		int   n_hs;
		int   n_vs;
		logic prev_hs;
		logic prev_vs;
		n_hs = 0;
		n_vs = 0;
		wait_line_start(9'd0);
		prev_hs = hsync;
		prev_vs = vsync;
		for (int i = 0; i < frame_cycles; i++) begin
			@(negedge clk);
			if (prev_hs && !hsync)
				n_hs++;
			if (prev_vs && !vsync)
				n_vs++;
			if (!hsync && de)
				abort_run("hsync went low while de was high");
			prev_hs = hsync;
			prev_vs = vsync;
		end
		check_count(v_total, n_hs, "hsync pulses per frame");
		check_count(1, n_vs, "vsync pulses per frame");
	endtask

	task automatic overlay_256();
		// data from line 1 is shown on line 2 and must be gone by line 4
		wait_line_start(9'd1);
		write_overlay(1'b0, 4'h0);
		wait_line_start(9'd2);
		write_overlay(1'b0, 4'h0);
		exp_bytes = wr_bytes;
		compare_line_pixels(9'd3, 1'b0, 4'h0);
		// nothing written during line 3, so line 4 must come out clean
		foreach (exp_bytes[k])
			exp_bytes[k] = 8'h00;
		compare_line_pixels(9'd4, 1'b0, 4'h0);
	endtask

	task automatic overlay_16_latch();
		write_reg(reg_vconf, 8'h01);
		write_reg(reg_palsel, 8'h03);
		wait_line_start(9'd4);
		write_overlay(1'b0, 4'h0);
		exp_bytes = wr_bytes;
		wait_line_start(9'd5);
		fork
			write_overlay(1'b1, 4'h9);
			compare_line_pixels(9'd5, 1'b1, 4'h3);
		join
		exp_bytes = wr_bytes;
		compare_line_pixels(9'd6, 1'b1, 4'h9);
	endtask

	task automatic line_interrupt();
		int n_int;
		n_int = 0;
		write_reg(reg_hint, 8'd5);
		write_reg(reg_vint_lo, 8'd6);
		write_reg(reg_vint_hi, 8'd0);
		wait_line_start(9'd0);
		for (int i = 0; i < frame_cycles; i++) begin
			if (int_start) begin
				check_line(9'd6, line, "line at int_start");
				n_int++;
			end
			@(negedge clk);
		end
		check_count(1, n_int, "int_start pulses per frame");
	endtask

	initial begin
		arst_n       <= 1'b0;
		d            <= '0;
		border_wr    <= 1'b0;
		vconf_wr     <= 1'b0;
		palsel_wr    <= 1'b0;
		hint_beg_wr  <= 1'b0;
		vint_begl_wr <= 1'b0;
		vint_begh_wr <= 1'b0;
		cram_addr    <= '0;
		cram_data    <= '0;
		cram_we      <= 1'b0;
		ts_waddr     <= '0;
		ts_wdata     <= '0;
		ts_we        <= 1'b0;
		border_model = 8'h00;
		lcg_state    = 32'd57;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		// the first frame runs while the palette fills and clears both banks
		fill_palette();
		border_frame();
		sync_pulses();
		overlay_256();
		overlay_16_latch();
		line_interrupt();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hw/video_pkg.sv
hw/video_ports.sv
hw/video_sync.sv
hw/video_linebuf.sv
hw/video_render.sv
hw/video_out.sv
hw/video_top.sv
dv/video_tb.sv

// ==== hw/video_linebuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_linebuf import video_pkg::*; #(
	parameter int h_act = 360
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             sel,
	input  wire logic [lb_aw-1:0] raddr,
	input  wire logic             rd_en,
	input  wire logic [lb_aw-1:0] waddr,
	input  wire logic [7:0]       wdata,
	input  wire logic             we,
	output logic [7:0]            rdata
);

	// two banks, sel picks the one on display
	logic [7:0] mem [2][2**lb_aw];

	logic [1:0] clr_en;
	logic [1:0] wr_en;

	// displayed bank is cleared behind the beam, the other one takes writer data
	assign clr_en = rd_en ? (sel ? 2'b10 : 2'b01) : 2'b00;
	assign wr_en  = we ? (sel ? 2'b01 : 2'b10) : 2'b00;

	always_ff @(posedge clk) begin
		for (int b = 0; b < 2; b++) begin
			if (clr_en[b])
				mem[b][raddr] <= '0;
			else if (wr_en[b])
				mem[b][waddr] <= wdata;
		end
	end

	// old contents come out before the clear lands
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rdata <= '0;
		else if (rd_en)
			rdata <= mem[sel][raddr];
		else
			rdata <= '0;
	end

	a_waddr_in_line: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> (waddr < lb_aw'(h_act))
	);

	a_no_bank_clash: assert property (
		@(posedge clk) disable iff (!arst_n)
		(clr_en & wr_en) == 2'b00
	);

endmodule

`default_nettype wire

// ==== hw/video_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_out import video_pkg::*; (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire pix_idx_t   index,
	input  wire logic       de_r,
	input  wire logic       hsync_d,
	input  wire logic       vsync_d,
	input  wire pix_idx_t   cram_addr,
	input  wire rgb_t       cram_data,
	input  wire logic       cram_we,
	output logic [4:0]      vred,
	output logic [4:0]      vgrn,
	output logic [4:0]      vblu,
	output logic            hsync,
	output logic            vsync,
	output logic            de
);

	// palette, 256 entries of rgb555
	rgb_t cram [256];
	rgb_t colour;

	always_ff @(posedge clk) begin
		if (cram_we)
			cram[cram_addr] <= cram_data;
		colour <= cram[index];
	end

	assign vred = colour.r;
	assign vgrn = colour.g;
	assign vblu = colour.b;

	// one more stage so syncs and enable match the palette read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end else begin
			hsync <= hsync_d;
			vsync <= vsync_d;
			de    <= de_r;
		end
	end

	a_cram_we_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(cram_we)
	);

endmodule

`default_nettype wire

// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// line buffer address width, one bank holds 512 pixels
	localparam int lb_aw = 9;

	// palette index
	typedef logic [7:0] pix_idx_t;

	// line number
	typedef logic [8:0] line_t;

	// rgb555 colour word, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb_t;

	// overlay byte split into nibbles for 16 colour mode
	typedef struct packed {
		logic [3:0] hi;
		logic [3:0] lo;
	} plex_nib_t;

	// one overlay byte, read either way by render
	typedef union packed {
		pix_idx_t  raw;
		plex_nib_t nib;
	} plex_u;

endpackage

`default_nettype wire

// ==== hw/video_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_ports import video_pkg::*; (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic [7:0] d,
	input  wire logic       border_wr,
	input  wire logic       vconf_wr,
	input  wire logic       palsel_wr,
	input  wire logic       hint_beg_wr,
	input  wire logic       vint_begl_wr,
	input  wire logic       vint_begh_wr,
	input  wire logic       line_start,
	output pix_idx_t        border,
	output logic            mode_16,
	output logic [3:0]      palsel,
	output logic [7:0]      hint_beg,
	output line_t           vint_beg
);

	// staged copies, moved to the live ones at line start
	logic       mode_16_stg;
	logic [3:0] palsel_stg;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			border      <= '0;
			mode_16_stg <= 1'b0;
			palsel_stg  <= '0;
			mode_16     <= 1'b0;
			palsel      <= '0;
			hint_beg    <= '0;
			vint_beg    <= '0;
		end else begin
			if (border_wr)
				border <= d;
			if (vconf_wr)
				mode_16_stg <= d[0];
			if (palsel_wr)
				palsel_stg <= d[3:0];
			if (hint_beg_wr)
				hint_beg <= d;
			if (vint_begl_wr)
				vint_beg[7:0] <= d;
			if (vint_begh_wr)
				vint_beg[8] <= d[0];
			// a mid-line write waits here until the next line begins
			if (line_start) begin
				mode_16 <= mode_16_stg;
				palsel  <= palsel_stg;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_render import video_pkg::*; (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic [7:0] rdata,
	input  wire logic       active_d,
	input  wire logic       mode_16,
	input  wire logic [3:0] palsel,
	input  wire pix_idx_t   border,
	output pix_idx_t        index,
	output logic            de_r
);

	plex_u    plex;
	pix_idx_t ovl_idx;
	logic     transp;

	assign plex = rdata;

	// 16 colours take the palette select as the upper half
	always_comb begin
		if (mode_16) begin
			ovl_idx = {palsel, plex.nib.lo};
			transp  = (plex.nib.lo == '0);
		end else begin
			ovl_idx = plex.raw;
			transp  = (plex.raw == '0);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			index <= '0;
			de_r  <= 1'b0;
		end else begin
			// border shows through transparent pixels and blanking
			if (active_d && !transp)
				index <= ovl_idx;
			else
				index <= border;
			de_r <= active_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_sync import video_pkg::*; #(
	parameter int h_total    = 448,
	parameter int h_act      = 360,
	parameter int h_sync_beg = 380,
	parameter int h_sync_end = 412,
	parameter int v_total    = 320,
	parameter int v_act      = 288,
	parameter int v_sync_beg = 300,
	parameter int v_sync_end = 304
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic [7:0]       hint_beg,
	input  wire line_t            vint_beg,
	output logic [lb_aw-1:0]      hcount,
	output line_t                 lcount,
	output logic                  line_start,
	output logic                  active,
	output logic                  hsync_raw,
	output logic                  vsync_raw,
	output logic                  int_start
);

	localparam logic [lb_aw-1:0] h_last = lb_aw'(h_total - 1);
	localparam line_t            v_last = line_t'(v_total - 1);

	logic h_wrap;
	logic int_hit;

	assign h_wrap  = (hcount == h_last);
	assign int_hit = (hcount == {1'b0, hint_beg}) && (lcount == vint_beg);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcount     <= '0;
			lcount     <= '0;
			line_start <= 1'b0;
			int_start  <= 1'b0;
		end else begin
			// registered so it lines up with hcount back at zero
			line_start <= h_wrap;
			int_start  <= int_hit;
			if (h_wrap) begin
				hcount <= '0;
				if (lcount == v_last)
					lcount <= '0;
				else
					lcount <= lcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// visible area
	assign active = (hcount < lb_aw'(h_act)) && (lcount < line_t'(v_act));

	// syncs are active low inside their windows
	assign hsync_raw = !((hcount >= lb_aw'(h_sync_beg)) && (hcount < lb_aw'(h_sync_end)));
	assign vsync_raw = !((lcount >= line_t'(v_sync_beg)) && (lcount < line_t'(v_sync_end)));

	a_line_start_at_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		line_start |-> (hcount == '0)
	);

	a_int_single_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		int_start |=> !int_start
	);

endmodule

`default_nettype wire

// ==== hw/video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_top import video_pkg::*; #(
	parameter int h_total    = 448,
	parameter int h_act      = 360,
	parameter int h_sync_beg = 380,
	parameter int h_sync_end = 412,
	parameter int v_total    = 320,
	parameter int v_act      = 288,
	parameter int v_sync_beg = 300,
	parameter int v_sync_end = 304
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic [7:0]       d,
	input  wire logic             border_wr,
	input  wire logic             vconf_wr,
	input  wire logic             palsel_wr,
	input  wire logic             hint_beg_wr,
	input  wire logic             vint_begl_wr,
	input  wire logic             vint_begh_wr,
	input  wire pix_idx_t         cram_addr,
	input  wire rgb_t             cram_data,
	input  wire logic             cram_we,
	input  wire logic [lb_aw-1:0] ts_waddr,
	input  wire logic [7:0]       ts_wdata,
	input  wire logic             ts_we,
	output logic [4:0]            vred,
	output logic [4:0]            vgrn,
	output logic [4:0]            vblu,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de,
	output logic                  int_start,
	output line_t                 line
);

	// port registers
	pix_idx_t   border;
	logic       mode_16;
	logic [3:0] palsel;
	logic [7:0] hint_beg;
	line_t      vint_beg;

	// counters and raw timing
	logic [lb_aw-1:0] hcount;
	line_t            lcount;
	logic             line_start;
	logic             active;
	logic             hsync_raw;
	logic             vsync_raw;

	// pipeline
	logic [7:0] ts_rdata;
	pix_idx_t   index;
	logic       de_r;
	logic       active_d;
	logic       hsync_d1;
	logic       vsync_d1;
	logic       hsync_d2;
	logic       vsync_d2;

	assign line = lcount;

	video_ports i_video_ports (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vconf_wr     (vconf_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.line_start   (line_start),
		.border       (border),
		.mode_16      (mode_16),
		.palsel       (palsel),
		.hint_beg     (hint_beg),
		.vint_beg     (vint_beg)
	);

	video_sync #(
		.h_total    (h_total),
		.h_act      (h_act),
		.h_sync_beg (h_sync_beg),
		.h_sync_end (h_sync_end),
		.v_total    (v_total),
		.v_act      (v_act),
		.v_sync_beg (v_sync_beg),
		.v_sync_end (v_sync_end)
	) i_video_sync (
		.clk        (clk),
		.arst_n     (arst_n),
		.hint_beg   (hint_beg),
		.vint_beg   (vint_beg),
		.hcount     (hcount),
		.lcount     (lcount),
		.line_start (line_start),
		.active     (active),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.int_start  (int_start)
	);

	// stage 1 matches the buffer read, stage 2 the render register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active_d <= 1'b0;
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			hsync_d2 <= 1'b1;
			vsync_d2 <= 1'b1;
		end else begin
			active_d <= active;
			hsync_d1 <= hsync_raw;
			vsync_d1 <= vsync_raw;
			hsync_d2 <= hsync_d1;
			vsync_d2 <= vsync_d1;
		end
	end

	video_linebuf #(
		.h_act (h_act)
	) i_video_linebuf (
		.clk    (clk),
		.arst_n (arst_n),
		.sel    (lcount[0]),
		.raddr  (hcount),
		.rd_en  (active),
		.waddr  (ts_waddr),
		.wdata  (ts_wdata),
		.we     (ts_we),
		.rdata  (ts_rdata)
	);

	video_render i_video_render (
		.clk      (clk),
		.arst_n   (arst_n),
		.rdata    (ts_rdata),
		.active_d (active_d),
		.mode_16  (mode_16),
		.palsel   (palsel),
		.border   (border),
		.index    (index),
		.de_r     (de_r)
	);

	video_out i_video_out (
		.clk       (clk),
		.arst_n    (arst_n),
		.index     (index),
		.de_r      (de_r),
		.hsync_d   (hsync_d2),
		.vsync_d   (vsync_d2),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.cram_we   (cram_we),
		.vred      (vred),
		.vgrn      (vgrn),
		.vblu      (vblu),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module video_tb -o video_sim
./obj_dir/video_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
